//--- logic/core_types_pkg.sv
// core-wide widths and types for mdp info and rob indices, imported by the rtl that needs them
`default_nettype none

package core_types_pkg;

	// ------------------------------------------------------------
	// rob

	localparam int LOG_ROB_ENTRIES = 6;

	// names one rob entry
	typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;

	// ------------------------------------------------------------
	// memory dependence predictor info

	localparam int MDP_CONF_WIDTH = 2;
	localparam int MDP_INFO_WIDTH = 8;

	// conf in the top bits, ssid in the low bits
	// conf of 0 means no store set yet
	typedef logic [MDP_INFO_WIDTH-1:0] mdp_info_t;

endpackage

`default_nettype wire

//--- logic/ssu_types_pkg.sv
// store set unit sizes and the request and update structs passed between the ssu blocks
`default_nettype none

package ssu_types_pkg;

	// ------------------------------------------------------------
	// sizes

	localparam int STORE_SET_COUNT = 64;
	localparam int SSID_WIDTH = $clog2(STORE_SET_COUNT);

	localparam int SSU_INPUT_BUFFER_ENTRIES = 2;
	localparam int SSU_FUNNEL_BUFFER_ENTRIES = 4;

	// 4 cam sources plus 2 commit sources
	localparam int SSU_SOURCE_COUNT = 6;

	typedef logic [SSID_WIDTH-1:0] ssid_t;

	// ------------------------------------------------------------
	// structs

	// implied dep between a load and a store/amo
	typedef struct packed {
		core_types_pkg::mdp_info_t ld_mdp_info;
		core_types_pkg::rob_index_t ld_rob_index;
		core_types_pkg::mdp_info_t stamo_mdp_info;
		core_types_pkg::rob_index_t stamo_rob_index;
	} ssu_cam_update_t;

	// implied no dep
	typedef struct packed {
		core_types_pkg::mdp_info_t mdp_info;
		core_types_pkg::rob_index_t rob_index;
	} ssu_commit_update_t;

	// a is the load side, b the store side
	// commit requests only fill pair a
	typedef struct packed {
		logic dep;
		core_types_pkg::mdp_info_t a_mdp_info;
		core_types_pkg::rob_index_t a_rob_index;
		core_types_pkg::mdp_info_t b_mdp_info;
		core_types_pkg::rob_index_t b_rob_index;
	} ssu_request_t;

	typedef struct packed {
		core_types_pkg::mdp_info_t mdp_info;
		core_types_pkg::rob_index_t rob_index;
	} rob_mdp_update_t;

endpackage

`default_nettype wire

//--- logic/ssu_input_buffer.sv
// per-source request fifo in front of the ssu arbiter; writes that find it full are dropped
`default_nettype none
`timescale 1ns/1ps

module ssu_input_buffer (
	input logic CLK,
	input logic nRST,

	input logic push,
	input ssu_types_pkg::ssu_request_t push_request,

	input logic pop,
	output ssu_types_pkg::ssu_request_t head,
	output logic not_empty
);
	import ssu_types_pkg::*;

	typedef logic [$clog2(SSU_INPUT_BUFFER_ENTRIES)-1:0] ptr_t;
	typedef logic [$clog2(SSU_INPUT_BUFFER_ENTRIES+1)-1:0] count_t;

	ssu_request_t entries [SSU_INPUT_BUFFER_ENTRIES];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	count_t count;
	logic full;
	logic push_accept;

	assign full = count == count_t'(SSU_INPUT_BUFFER_ENTRIES);
	assign not_empty = count != '0;
	assign head = entries[rd_ptr];

	// updates are hints, losing one is safe
	assign push_accept = push && !full;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_accept) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + count_t'(push_accept) - count_t'(pop);
		end
	end

	always_ff @(posedge CLK) begin
		if (push_accept) begin
			entries[wr_ptr] <= push_request;
		end
	end

	// arbiter must only grant a non-empty buffer
	assert property (@(posedge CLK) disable iff (!nRST) pop |-> not_empty)
		else $error("ssu input buffer popped while empty");

endmodule

`default_nettype wire

//--- logic/ssu_store_set_logic.sv
// store set rules for one granted request plus the rotating ssid allocator, used inside ssu
`default_nettype none
`timescale 1ns/1ps

module ssu_store_set_logic (
	input logic CLK,
	input logic nRST,

	input logic request_valid,
	input ssu_types_pkg::ssu_request_t request,

	output logic update_a_valid,
	output ssu_types_pkg::rob_mdp_update_t update_a,
	output logic update_b_valid,
	output ssu_types_pkg::rob_mdp_update_t update_b
);
	import core_types_pkg::*;
	import ssu_types_pkg::*;

	logic [MDP_CONF_WIDTH-1:0] a_conf;
	logic [MDP_CONF_WIDTH-1:0] b_conf;
	ssid_t a_ssid;
	ssid_t b_ssid;
	ssid_t dep_ssid;
	ssid_t alloc_ssid;
	logic a_has_set;
	logic b_has_set;
	logic allocate;

	assign a_conf = request.a_mdp_info[MDP_INFO_WIDTH-1 -: MDP_CONF_WIDTH];
	assign b_conf = request.b_mdp_info[MDP_INFO_WIDTH-1 -: MDP_CONF_WIDTH];
	assign a_ssid = request.a_mdp_info[SSID_WIDTH-1:0];
	assign b_ssid = request.b_mdp_info[SSID_WIDTH-1:0];
	assign a_has_set = a_conf != '0;
	assign b_has_set = b_conf != '0;

	// neither side in a set yet
	assign allocate = request_valid && request.dep && !a_has_set && !b_has_set;

	// merge toward the smaller ssid
	always_comb begin
		if (a_has_set && b_has_set) begin
			dep_ssid = (a_ssid < b_ssid) ? a_ssid : b_ssid;
		end else if (a_has_set) begin
			dep_ssid = a_ssid;
		end else if (b_has_set) begin
			dep_ssid = b_ssid;
		end else begin
			dep_ssid = alloc_ssid;
		end
	end

	always_comb begin
		update_a.rob_index = request.a_rob_index;
		update_b.rob_index = request.b_rob_index;
		if (request.dep) begin
			// dep saturates conf on both sides
			update_a_valid = request_valid;
			update_b_valid = request_valid;
			update_a.mdp_info = {{MDP_CONF_WIDTH{1'b1}}, dep_ssid};
			update_b.mdp_info = {{MDP_CONF_WIDTH{1'b1}}, dep_ssid};
		end else begin
			// commit decays conf, nothing to do once it hits 0
			update_a_valid = request_valid && a_has_set;
			update_b_valid = 1'b0;
			update_a.mdp_info = {a_conf - 1'b1, a_ssid};
			update_b.mdp_info = request.b_mdp_info;
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			alloc_ssid <= '0;
		end else if (allocate) begin
			alloc_ssid <= (alloc_ssid == ssid_t'(STORE_SET_COUNT - 1)) ? '0 : alloc_ssid + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/ssu_funnel_buffer.sv
// two-in one-out fifo collecting store set results and sending them to the rob under valid/ready
`default_nettype none
`timescale 1ns/1ps

module ssu_funnel_buffer (
	input logic CLK,
	input logic nRST,

	input logic push_a_valid,
	input ssu_types_pkg::rob_mdp_update_t push_a,
	input logic push_b_valid,
	input ssu_types_pkg::rob_mdp_update_t push_b,
	output logic room_for_two,

	output logic head_valid,
	output ssu_types_pkg::rob_mdp_update_t head,
	input logic ready
);
	import ssu_types_pkg::*;

	typedef logic [$clog2(SSU_FUNNEL_BUFFER_ENTRIES)-1:0] ptr_t;
	typedef logic [$clog2(SSU_FUNNEL_BUFFER_ENTRIES+1)-1:0] count_t;

	rob_mdp_update_t entries [SSU_FUNNEL_BUFFER_ENTRIES];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	ptr_t b_slot;
	count_t count;
	count_t push_count;
	logic pop;

	assign push_count = count_t'(push_a_valid) + count_t'(push_b_valid);
	assign pop = head_valid && ready;

	// b lands behind a when both come in the same cycle
	assign b_slot = push_a_valid ? wr_ptr + 1'b1 : wr_ptr;

	assign head_valid = count != '0;
	assign head = entries[rd_ptr];

	// from registered count only, so a same-cycle pop does not count
	assign room_for_two = count <= count_t'(SSU_FUNNEL_BUFFER_ENTRIES - 2);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			wr_ptr <= wr_ptr + ptr_t'(push_count);
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + push_count - count_t'(pop);
		end
	end

	always_ff @(posedge CLK) begin
		if (push_a_valid) begin
			entries[wr_ptr] <= push_a;
		end
		if (push_b_valid) begin
			entries[b_slot] <= push_b;
		end
	end

	// ------------------------------------------------------------
	// checks

	// the arbiter upstream has to hold off while room is short
	assert property (@(posedge CLK) disable iff (!nRST)
		(push_a_valid || push_b_valid) |-> room_for_two)
		else $error("ssu funnel pushed without room for two");

	assert property (@(posedge CLK) disable iff (!nRST)
		(head_valid && !ready) |=> (head_valid && $stable(head)))
		else $error("ssu funnel head changed while stalled");

endmodule

`default_nettype wire

//--- logic/ssu.sv
// store set unit core: six input buffers, round-robin arbiter, store set logic and rob funnel
`default_nettype none
`timescale 1ns/1ps

module ssu (
	input logic CLK,
	input logic nRST,

	input logic ldu_cq_cam_update_valid,
	input ssu_types_pkg::ssu_cam_update_t ldu_cq_cam_update,
	input logic ldu_mq_cam_update_valid,
	input ssu_types_pkg::ssu_cam_update_t ldu_mq_cam_update,
	input logic ldu_cq_commit_update_valid,
	input ssu_types_pkg::ssu_commit_update_t ldu_cq_commit_update,
	input logic stamofu_cq_cam_bank0_update_valid,
	input ssu_types_pkg::ssu_cam_update_t stamofu_cq_cam_bank0_update,
	input logic stamofu_cq_cam_bank1_update_valid,
	input ssu_types_pkg::ssu_cam_update_t stamofu_cq_cam_bank1_update,
	input logic stamofu_cq_commit_update_valid,
	input ssu_types_pkg::ssu_commit_update_t stamofu_cq_commit_update,

	output logic rob_mdp_update_valid,
	output ssu_types_pkg::rob_mdp_update_t rob_mdp_update,
	input logic rob_mdp_update_ready
);
	import ssu_types_pkg::*;

	typedef logic [$clog2(SSU_SOURCE_COUNT)-1:0] source_index_t;

	logic [SSU_SOURCE_COUNT-1:0] push_valids;
	ssu_request_t push_requests [SSU_SOURCE_COUNT];
	ssu_request_t heads [SSU_SOURCE_COUNT];
	logic [SSU_SOURCE_COUNT-1:0] not_empty;
	logic [SSU_SOURCE_COUNT-1:0] grant;
	source_index_t grant_index;
	source_index_t rr_ptr;
	logic room_for_two;
	logic update_a_valid;
	rob_mdp_update_t update_a;
	logic update_b_valid;
	rob_mdp_update_t update_b;

	function automatic ssu_request_t cam_request(input ssu_cam_update_t update);
		return '{1'b1, update.ld_mdp_info, update.ld_rob_index,
			update.stamo_mdp_info, update.stamo_rob_index};
	endfunction

	function automatic ssu_request_t commit_request(input ssu_commit_update_t update);
		return '{1'b0, update.mdp_info, update.rob_index, '0, '0};
	endfunction

	// ------------------------------------------------------------
	// input buffers, one per source

	assign push_valids = {stamofu_cq_commit_update_valid, stamofu_cq_cam_bank1_update_valid,
		stamofu_cq_cam_bank0_update_valid, ldu_cq_commit_update_valid,
		ldu_mq_cam_update_valid, ldu_cq_cam_update_valid};

	assign push_requests[0] = cam_request(ldu_cq_cam_update);
	assign push_requests[1] = cam_request(ldu_mq_cam_update);
	assign push_requests[2] = commit_request(ldu_cq_commit_update);
	assign push_requests[3] = cam_request(stamofu_cq_cam_bank0_update);
	assign push_requests[4] = cam_request(stamofu_cq_cam_bank1_update);
	assign push_requests[5] = commit_request(stamofu_cq_commit_update);

	for (genvar i = 0; i < SSU_SOURCE_COUNT; i++) begin : gen_input_buffer
		ssu_input_buffer input_buffer_inst (
			.CLK(CLK),
			.nRST(nRST),
			.push(push_valids[i]),
			.push_request(push_requests[i]),
			.pop(grant[i]),
			.head(heads[i]),
			.not_empty(not_empty[i])
		);
	end

	// ------------------------------------------------------------
	// round-robin arbiter

	// search starts at the source after the last grant
	always_comb begin
		int candidate;
		grant = '0;
		grant_index = '0;
		for (int i = 0; i < SSU_SOURCE_COUNT; i++) begin
			candidate = int'(rr_ptr) + i;
			if (candidate >= SSU_SOURCE_COUNT) begin
				candidate = candidate - SSU_SOURCE_COUNT;
			end
			if (grant == '0 && not_empty[candidate] && room_for_two) begin
				grant[candidate] = 1'b1;
				grant_index = source_index_t'(candidate);
			end
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			rr_ptr <= '0;
		end else if (grant != '0) begin
			rr_ptr <= (grant_index == source_index_t'(SSU_SOURCE_COUNT - 1)) ?
				'0 : grant_index + 1'b1;
		end
	end

	// at most one grant, and no idle cycle while a buffer waits and the funnel has room
	assert property (@(posedge CLK) disable iff (!nRST)
		$onehot0(grant) && ((grant != '0) == (room_for_two && not_empty != '0)))
		else $error("ssu arbiter grant not one-hot or a waiting source left idle");

	// ------------------------------------------------------------
	// store set logic and funnel

	ssu_store_set_logic store_set_logic_inst (
		.CLK(CLK),
		.nRST(nRST),
		.request_valid(grant != '0),
		.request(heads[grant_index]),
		.update_a_valid(update_a_valid),
		.update_a(update_a),
		.update_b_valid(update_b_valid),
		.update_b(update_b)
	);

	ssu_funnel_buffer funnel_buffer_inst (
		.CLK(CLK),
		.nRST(nRST),
		.push_a_valid(update_a_valid),
		.push_a(update_a),
		.push_b_valid(update_b_valid),
		.push_b(update_b),
		.room_for_two(room_for_two),
		.head_valid(rob_mdp_update_valid),
		.head(rob_mdp_update),
		.ready(rob_mdp_update_ready)
	);

endmodule

`default_nettype wire

//--- logic/ssu_wrapper.sv
// top level around ssu; registers every input and the rob ready, and outputs accepted updates
`default_nettype none
`timescale 1ns/1ps

module ssu_wrapper (
	input logic CLK,
	input logic nRST,

	input logic next_ldu_cq_cam_update_valid,
	input ssu_types_pkg::ssu_cam_update_t next_ldu_cq_cam_update,
	input logic next_ldu_mq_cam_update_valid,
	input ssu_types_pkg::ssu_cam_update_t next_ldu_mq_cam_update,
	input logic next_ldu_cq_commit_update_valid,
	input ssu_types_pkg::ssu_commit_update_t next_ldu_cq_commit_update,
	input logic next_stamofu_cq_cam_bank0_update_valid,
	input ssu_types_pkg::ssu_cam_update_t next_stamofu_cq_cam_bank0_update,
	input logic next_stamofu_cq_cam_bank1_update_valid,
	input ssu_types_pkg::ssu_cam_update_t next_stamofu_cq_cam_bank1_update,
	input logic next_stamofu_cq_commit_update_valid,
	input ssu_types_pkg::ssu_commit_update_t next_stamofu_cq_commit_update,

	output logic last_rob_mdp_update_valid,
	output ssu_types_pkg::rob_mdp_update_t last_rob_mdp_update,
	input logic next_rob_mdp_update_ready
);
	import ssu_types_pkg::*;

	logic ldu_cq_cam_update_valid;
	ssu_cam_update_t ldu_cq_cam_update;
	logic ldu_mq_cam_update_valid;
	ssu_cam_update_t ldu_mq_cam_update;
	logic ldu_cq_commit_update_valid;
	ssu_commit_update_t ldu_cq_commit_update;
	logic stamofu_cq_cam_bank0_update_valid;
	ssu_cam_update_t stamofu_cq_cam_bank0_update;
	logic stamofu_cq_cam_bank1_update_valid;
	ssu_cam_update_t stamofu_cq_cam_bank1_update;
	logic stamofu_cq_commit_update_valid;
	ssu_commit_update_t stamofu_cq_commit_update;

	logic rob_mdp_update_valid;
	rob_mdp_update_t rob_mdp_update;
	logic rob_mdp_update_ready;

	ssu ssu_inst (.*);

	// ------------------------------------------------------------
	// registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			ldu_cq_cam_update_valid <= 1'b0;
			ldu_mq_cam_update_valid <= 1'b0;
			ldu_cq_commit_update_valid <= 1'b0;
			stamofu_cq_cam_bank0_update_valid <= 1'b0;
			stamofu_cq_cam_bank1_update_valid <= 1'b0;
			stamofu_cq_commit_update_valid <= 1'b0;
			rob_mdp_update_ready <= 1'b0;
			last_rob_mdp_update_valid <= 1'b0;
		end else begin
			ldu_cq_cam_update_valid <= next_ldu_cq_cam_update_valid;
			ldu_mq_cam_update_valid <= next_ldu_mq_cam_update_valid;
			ldu_cq_commit_update_valid <= next_ldu_cq_commit_update_valid;
			stamofu_cq_cam_bank0_update_valid <= next_stamofu_cq_cam_bank0_update_valid;
			stamofu_cq_cam_bank1_update_valid <= next_stamofu_cq_cam_bank1_update_valid;
			stamofu_cq_commit_update_valid <= next_stamofu_cq_commit_update_valid;
			rob_mdp_update_ready <= next_rob_mdp_update_ready;
			// one pulse per update the funnel actually hands over
			last_rob_mdp_update_valid <= rob_mdp_update_valid && rob_mdp_update_ready;
		end
	end

	always_ff @(posedge CLK) begin
		ldu_cq_cam_update <= next_ldu_cq_cam_update;
		ldu_mq_cam_update <= next_ldu_mq_cam_update;
		ldu_cq_commit_update <= next_ldu_cq_commit_update;
		stamofu_cq_cam_bank0_update <= next_stamofu_cq_cam_bank0_update;
		stamofu_cq_cam_bank1_update <= next_stamofu_cq_cam_bank1_update;
		stamofu_cq_commit_update <= next_stamofu_cq_commit_update;
		last_rob_mdp_update <= rob_mdp_update;
	end

endmodule

`default_nettype wire

//--- testbench/ssu_tb_tasks.svh
// drive tasks, store set reference model, compare tasks and directed tests for the ssu testbench
`ifndef SSU_TB_TASKS_SVH
`define SSU_TB_TASKS_SVH

	localparam int CONF_MAX = (1 << MDP_CONF_WIDTH) - 1;
	localparam int WAIT_LIMIT = 100;

	// reference allocator, next fresh store set
	int model_next_ssid = 0;
	rob_mdp_update_t pending [$];

	// ------------------------------------------------------------
	// reporting and compare

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic compare_mdp_info(input string name, input mdp_info_t exp, input mdp_info_t act);
		if (act !== exp) begin
			stop_run($sformatf("mismatch %s: expected mdp_info 0x%h, actual 0x%h", name, exp, act));
		end
	endtask

	task automatic compare_rob_index(input string name, input rob_index_t exp,
		input rob_index_t act);
		if (act !== exp) begin
			stop_run($sformatf("mismatch %s: expected rob_index %0d, actual %0d", name, exp, act));
		end
	endtask

	task automatic check_update(input string name, input rob_mdp_update_t exp,
		input rob_mdp_update_t act);
		compare_rob_index(name, exp.rob_index, act.rob_index);
		compare_mdp_info(name, exp.mdp_info, act.mdp_info);
	endtask

	// ------------------------------------------------------------
	// reference model

	function automatic mdp_info_t make_info(input int conf, input int ssid);
		return mdp_info_t'(conf * STORE_SET_COUNT + ssid);
	endfunction

	// both sides end up with this info
	function automatic mdp_info_t model_dep(input mdp_info_t ld, input mdp_info_t st);
		int ld_conf;
		int st_conf;
		int ld_ssid;
		int st_ssid;
		int ssid;
		ld_conf = int'(ld) / STORE_SET_COUNT;
		st_conf = int'(st) / STORE_SET_COUNT;
		ld_ssid = int'(ld) % STORE_SET_COUNT;
		st_ssid = int'(st) % STORE_SET_COUNT;
		if (ld_conf != 0 && st_conf != 0) begin
			ssid = (ld_ssid < st_ssid) ? ld_ssid : st_ssid;
		end else if (ld_conf != 0 || st_conf != 0) begin
			ssid = (ld_conf != 0) ? ld_ssid : st_ssid;
		end else begin
			ssid = model_next_ssid;
			model_next_ssid = (model_next_ssid + 1) % STORE_SET_COUNT;
		end
		return make_info(CONF_MAX, ssid);
	endfunction

	// returns 0 when the commit yields nothing
	function automatic bit model_decay(input mdp_info_t info, output mdp_info_t result);
		int conf;
		conf = int'(info) / STORE_SET_COUNT;
		result = make_info((conf > 0) ? conf - 1 : 0, int'(info) % STORE_SET_COUNT);
		return conf != 0;
	endfunction

	// ------------------------------------------------------------
	// drive

	task automatic clear_inputs();
		next_ldu_cq_cam_update_valid = 1'b0;
		next_ldu_mq_cam_update_valid = 1'b0;
		next_ldu_cq_commit_update_valid = 1'b0;
		next_stamofu_cq_cam_bank0_update_valid = 1'b0;
		next_stamofu_cq_cam_bank1_update_valid = 1'b0;
		next_stamofu_cq_commit_update_valid = 1'b0;
		next_ldu_cq_cam_update = '0;
		next_ldu_mq_cam_update = '0;
		next_ldu_cq_commit_update = '0;
		next_stamofu_cq_cam_bank0_update = '0;
		next_stamofu_cq_cam_bank1_update = '0;
		next_stamofu_cq_commit_update = '0;
		next_rob_mdp_update_ready = 1'b0;
	endtask

	// cam sources 0 ldu cq, 1 ldu mq, 2 stamofu bank0, 3 stamofu bank1
	task automatic set_cam(input int source, input ssu_cam_update_t update);
		case (source)
			0: {next_ldu_cq_cam_update_valid, next_ldu_cq_cam_update} = {1'b1, update};
			1: {next_ldu_mq_cam_update_valid, next_ldu_mq_cam_update} = {1'b1, update};
			2: {next_stamofu_cq_cam_bank0_update_valid, next_stamofu_cq_cam_bank0_update} =
				{1'b1, update};
			default: {next_stamofu_cq_cam_bank1_update_valid, next_stamofu_cq_cam_bank1_update} =
				{1'b1, update};
		endcase
	endtask

	// commit sources 0 ldu cq, 1 stamofu cq
	task automatic set_commit(input int source, input ssu_commit_update_t update);
		if (source == 0) begin
			next_ldu_cq_commit_update_valid = 1'b1;
			next_ldu_cq_commit_update = update;
		end else begin
			next_stamofu_cq_commit_update_valid = 1'b1;
			next_stamofu_cq_commit_update = update;
		end
	endtask

	// one clock, then drop the update valids
	task automatic next_cycle();
		@(posedge CLK);
		#DRIVE_DELAY;
		next_ldu_cq_cam_update_valid = 1'b0;
		next_ldu_mq_cam_update_valid = 1'b0;
		next_ldu_cq_commit_update_valid = 1'b0;
		next_stamofu_cq_cam_bank0_update_valid = 1'b0;
		next_stamofu_cq_cam_bank1_update_valid = 1'b0;
		next_stamofu_cq_commit_update_valid = 1'b0;
	endtask

	task automatic wait_for_updates(input int count, input string name);
		int cycles;
		cycles = 0;
		while (seen.size() < count && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (seen.size() < count) begin
			stop_run($sformatf("%s: only %0d of %0d updates reached the rob in %0d cycles",
				name, seen.size(), count, WAIT_LIMIT));
		end
	endtask

	task automatic expect_quiet(input int cycles, input string name);
		repeat (cycles) begin
			next_cycle();
		end
		if (seen.size() != 0) begin
			stop_run($sformatf("%s: %0d unexpected updates reached the rob", name, seen.size()));
		end
	endtask

	task automatic run_cam(input string name, input int source, input mdp_info_t ld_info,
		input rob_index_t ld_rob, input mdp_info_t st_info, input rob_index_t st_rob);
		mdp_info_t exp_info;
		exp_info = model_dep(ld_info, st_info);
		seen.delete();
		set_cam(source, ssu_cam_update_t'{ld_info, ld_rob, st_info, st_rob});
		next_cycle();
		wait_for_updates(2, name);
		// load side comes out first
		check_update(name, rob_mdp_update_t'{exp_info, ld_rob}, seen[0]);
		check_update(name, rob_mdp_update_t'{exp_info, st_rob}, seen[1]);
	endtask

	task automatic run_commit(input string name, input int source, input mdp_info_t info,
		input rob_index_t rob);
		mdp_info_t exp_info;
		seen.delete();
		set_commit(source, ssu_commit_update_t'{info, rob});
		next_cycle();
		if (model_decay(info, exp_info)) begin
			wait_for_updates(1, name);
			check_update(name, rob_mdp_update_t'{exp_info, rob}, seen[0]);
		end else begin
			expect_quiet(20, name);
		end
	endtask

	// ------------------------------------------------------------
	// directed tests

	task automatic test_reset();
		seen.delete();
		next_rob_mdp_update_ready = 1'b1;
		expect_quiet(20, "reset");
	endtask

	task automatic test_allocation();
		// conf 0 with junk ssid bits, must still allocate
		run_cam("allocation first", 0, make_info(0, 7), 6'd1, make_info(0, 42), 6'd2);
		run_cam("allocation second", 1, make_info(0, 0), 6'd3, make_info(0, 63), 6'd4);
	endtask

	task automatic test_merge();
		run_cam("merge store smaller", 1, make_info(1, 9), 6'd10, make_info(2, 5), 6'd11);
		run_cam("merge load smaller", 0, make_info(3, 4), 6'd12, make_info(1, 20), 6'd13);
		run_cam("merge load only", 2, make_info(2, 12), 6'd14, make_info(0, 3), 6'd15);
		run_cam("merge store only", 3, make_info(0, 40), 6'd16, make_info(3, 33), 6'd17);
	endtask

	task automatic test_decay();
		run_commit("decay ldu", 0, make_info(2, 17), 6'd20);
		run_commit("decay stamofu", 1, make_info(1, 30), 6'd21);
		run_commit("decay at zero", 0, make_info(0, 17), 6'd22);
	endtask

	task automatic test_contention();
		mdp_info_t info;
		mdp_info_t exp_info;
		int idx;
		seen.delete();
		pending.delete();
		next_rob_mdp_update_ready = 1'b0;
		// ready is registered in the wrapper
		repeat (2) begin
			next_cycle();
		end
		for (int s = 0; s < 4; s++) begin
			exp_info = model_dep(make_info(1, 8 + s), make_info(2, 3 + s));
			set_cam(s, ssu_cam_update_t'{make_info(1, 8 + s), rob_index_t'(32 + 2 * s),
				make_info(2, 3 + s), rob_index_t'(33 + 2 * s)});
			pending.push_back(rob_mdp_update_t'{exp_info, rob_index_t'(32 + 2 * s)});
			pending.push_back(rob_mdp_update_t'{exp_info, rob_index_t'(33 + 2 * s)});
		end
		for (int c = 0; c < 2; c++) begin
			info = make_info(3, 50 + c);
			set_commit(c, ssu_commit_update_t'{info, rob_index_t'(48 + c)});
			if (model_decay(info, exp_info)) begin
				pending.push_back(rob_mdp_update_t'{exp_info, rob_index_t'(48 + c)});
			end
		end
		next_cycle();
		expect_quiet(20, "contention stalled");
		next_rob_mdp_update_ready = 1'b1;
		wait_for_updates(pending.size(), "contention drain");
		repeat (10) begin
			next_cycle();
		end
		if (seen.size() != pending.size()) begin
			stop_run($sformatf("contention: %0d updates arrived, %0d expected",
				seen.size(), pending.size()));
		end
		// match by rob index, each expected update used once
		for (int i = 0; i < seen.size(); i++) begin
			idx = -1;
			for (int j = 0; j < pending.size(); j++) begin
				if (pending[j].rob_index == seen[i].rob_index) begin
					idx = j;
				end
			end
			if (idx < 0) begin
				stop_run($sformatf("contention: rob index %0d arrived but was not expected",
					seen[i].rob_index));
			end else begin
				check_update("contention", pending[idx], seen[i]);
				pending.delete(idx);
			end
		end
	endtask

`endif

//--- testbench/ssu_tb.sv
// testbench top for ssu_wrapper; runs the directed store set tests and reports pass or fail
`default_nettype none
`timescale 1ns/1ps

module ssu_tb;
	import core_types_pkg::*;
	import ssu_types_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int DRIVE_DELAY = 1;
	localparam int TEST_COUNT = 5;
	localparam int CYCLES_PER_TEST = 200;

	logic CLK;
	logic nRST;

	logic next_ldu_cq_cam_update_valid;
	ssu_cam_update_t next_ldu_cq_cam_update;
	logic next_ldu_mq_cam_update_valid;
	ssu_cam_update_t next_ldu_mq_cam_update;
	logic next_ldu_cq_commit_update_valid;
	ssu_commit_update_t next_ldu_cq_commit_update;
	logic next_stamofu_cq_cam_bank0_update_valid;
	ssu_cam_update_t next_stamofu_cq_cam_bank0_update;
	logic next_stamofu_cq_cam_bank1_update_valid;
	ssu_cam_update_t next_stamofu_cq_cam_bank1_update;
	logic next_stamofu_cq_commit_update_valid;
	ssu_commit_update_t next_stamofu_cq_commit_update;

	logic last_rob_mdp_update_valid;
	rob_mdp_update_t last_rob_mdp_update;
	logic next_rob_mdp_update_ready;

	// every delivered update, in arrival order
	rob_mdp_update_t seen [$];

	ssu_wrapper ssu_wrapper_inst (.*);

	`include "ssu_tb_tasks.svh"

	initial begin
		CLK = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) CLK = ~CLK;
		end
	end

	// output is registered, so it has settled by the falling edge
	always @(negedge CLK) begin
		if (nRST && last_rob_mdp_update_valid) begin
			seen.push_back(last_rob_mdp_update);
		end
	end

	// ------------------------------------------------------------
	// watchdog

	initial begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		stop_run("timeout: the tests did not finish within the cycle budget");
	end

	// ------------------------------------------------------------
	// test sequence

	initial begin
		clear_inputs();
		nRST = 1'b0;
		repeat (3) begin
			@(posedge CLK);
		end
		#DRIVE_DELAY;
		nRST = 1'b1;

		test_reset();
		test_allocation();
		test_merge();
		test_decay();
		test_contention();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+testbench
logic/core_types_pkg.sv
logic/ssu_types_pkg.sv
logic/ssu_input_buffer.sv
logic/ssu_store_set_logic.sv
logic/ssu_funnel_buffer.sv
logic/ssu.sv
logic/ssu_wrapper.sv
testbench/ssu_tb.sv

//--- Makefile
TOP = ssu_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build ssu_tb with verilator, run it, fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
